// ==== hdl/rf_defs.svh ====
`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// micro-op layout.
`define WIDTH_UOP        16
`define UOP_TYPE         3:0
`define UOP_SRC1         5:4
`define UOP_SRC2         7:6

// instruction type codes.
`define ITYPE_IDX_ALU    4'd1

// first operand source.
`define CTRL_SRC1_RF     2'd0
`define CTRL_SRC1_PC     2'd1
`define CTRL_SRC1_ZERO   2'd2
`define CTRL_SRC1_CNTID  2'd3

// second operand source.
`define CTRL_SRC2_RF     2'd0
`define CTRL_SRC2_IMM    2'd1
`define CTRL_SRC2_CNTL   2'd2
`define CTRL_SRC2_CNTH   2'd3

`endif

// ==== hdl/rf_pkg.sv ====
`include "rf_defs.svh"

package rf_pkg;

    // data word, also used for pc and immediate.
    typedef logic [31:0] word_t;

    // architectural register number.
    typedef logic [4:0] reg_idx_t;

    typedef logic [`WIDTH_UOP-1:0] uop_t;

    // exception code carried along unchanged.
    typedef logic [6:0] exp_t;

    // stable counter value.
    typedef logic [63:0] cnt_t;

    typedef logic [1:0] src1_sel_t;
    typedef logic [1:0] src2_sel_t;

endpackage

// ==== hdl/stable_counter.sv ====
`timescale 1ns/1ps

module stable_counter (
    input  logic          clk,
    input  logic          arst_n,
    output rf_pkg::cnt_t  count
);

    // counts every cycle since reset, read by rdcntvl and rdcntvh.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            count <= count + 64'd1;
        end
    end

endmodule

// ==== hdl/regfile_2w4r.sv ====
`timescale 1ns/1ps

module regfile_2w4r (
    input  logic              clk,
    input  logic              wr_en_0,
    input  logic              wr_en_1,
    input  rf_pkg::reg_idx_t  wr_addr_0,
    input  rf_pkg::reg_idx_t  wr_addr_1,
    input  rf_pkg::word_t     wr_data_0,
    input  rf_pkg::word_t     wr_data_1,
    input  rf_pkg::reg_idx_t  rd_addr_0a,
    input  rf_pkg::reg_idx_t  rd_addr_0b,
    input  rf_pkg::reg_idx_t  rd_addr_1a,
    input  rf_pkg::reg_idx_t  rd_addr_1b,
    output rf_pkg::word_t     rd_data_0a,
    output rf_pkg::word_t     rd_data_0b,
    output rf_pkg::word_t     rd_data_1a,
    output rf_pkg::word_t     rd_data_1b
);
    import rf_pkg::*;

    word_t    mem [32];
    reg_idx_t rd_addr [4];
    word_t    rd_data [4];

    // port 1 is written last, so it wins when both target one register.
    always_ff @(posedge clk) begin
        if (wr_en_0 && wr_addr_0 != 5'd0) begin
            mem[wr_addr_0] <= wr_data_0;
        end
        if (wr_en_1 && wr_addr_1 != 5'd0) begin
            mem[wr_addr_1] <= wr_data_1;
        end
    end

    assign rd_addr = '{rd_addr_0a, rd_addr_0b, rd_addr_1a, rd_addr_1b};

    for (genvar i = 0; i < 4; i++) begin : g_read
        // writes of this cycle are forwarded into the read.
        always_comb begin
            if (rd_addr[i] == 5'd0) begin
                rd_data[i] = '0;
            end else if (wr_en_1 && wr_addr_1 == rd_addr[i]) begin
                rd_data[i] = wr_data_1;
            end else if (wr_en_0 && wr_addr_0 == rd_addr[i]) begin
                rd_data[i] = wr_data_0;
            end else begin
                rd_data[i] = mem[rd_addr[i]];
            end
        end
    end

    assign rd_data_0a = rd_data[0];
    assign rd_data_0b = rd_data[1];
    assign rd_data_1a = rd_data[2];
    assign rd_data_1b = rd_data[3];

endmodule

// ==== hdl/operand_select.sv ====
`timescale 1ns/1ps
`include "rf_defs.svh"

module operand_select #(
    parameter bit sel_alu_only = 1'b0
) (
    input  rf_pkg::uop_t   uop,
    input  rf_pkg::word_t  pc,
    input  rf_pkg::word_t  imm,
    input  rf_pkg::cnt_t   count,
    input  rf_pkg::word_t  rf_a,
    input  rf_pkg::word_t  rf_b,
    output rf_pkg::word_t  src_a,
    output rf_pkg::word_t  src_b
);
    import rf_pkg::*;

    src1_sel_t src1;
    src2_sel_t src2;
    logic      use_sel;

    // lane 0 honours the selects for ALU ops only.
    assign use_sel = !sel_alu_only || (uop[`UOP_TYPE] == `ITYPE_IDX_ALU);

    assign src1 = use_sel ? uop[`UOP_SRC1] : `CTRL_SRC1_RF;
    assign src2 = use_sel ? uop[`UOP_SRC2] : `CTRL_SRC2_RF;

    always_comb begin
        case (src1)
            `CTRL_SRC1_PC:    src_a = pc;
            `CTRL_SRC1_ZERO:  src_a = '0;
            // single core, so the counter id is always zero.
            `CTRL_SRC1_CNTID: src_a = '0;
            default:          src_a = rf_a;
        endcase
    end

    always_comb begin
        case (src2)
            `CTRL_SRC2_IMM:  src_b = imm;
            `CTRL_SRC2_CNTL: src_b = count[31:0];
            `CTRL_SRC2_CNTH: src_b = count[63:32];
            default:         src_b = rf_b;
        endcase
    end

endmodule

// ==== hdl/rf_read_stage.sv ====
`timescale 1ns/1ps

module rf_read_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr_en_0,
    input  logic              wr_en_1,
    input  rf_pkg::reg_idx_t  wr_addr_0,
    input  rf_pkg::reg_idx_t  wr_addr_1,
    input  rf_pkg::word_t     wr_data_0,
    input  rf_pkg::word_t     wr_data_1,
    input  rf_pkg::cnt_t      count,
    input  logic              l0_en,
    input  rf_pkg::uop_t      l0_uop,
    input  rf_pkg::reg_idx_t  l0_rd,
    input  rf_pkg::reg_idx_t  l0_rj,
    input  rf_pkg::reg_idx_t  l0_rk,
    input  rf_pkg::word_t     l0_pc,
    input  rf_pkg::word_t     l0_pc_next,
    input  rf_pkg::exp_t      l0_exp,
    input  rf_pkg::word_t     l0_imm,
    input  logic              l1_en,
    input  rf_pkg::uop_t      l1_uop,
    input  rf_pkg::reg_idx_t  l1_rd,
    input  rf_pkg::reg_idx_t  l1_rj,
    input  rf_pkg::reg_idx_t  l1_rk,
    input  rf_pkg::word_t     l1_pc,
    input  rf_pkg::word_t     l1_pc_next,
    input  rf_pkg::exp_t      l1_exp,
    input  rf_pkg::word_t     l1_imm,
    output logic              l0_en_out,
    output rf_pkg::uop_t      l0_uop_out,
    output rf_pkg::reg_idx_t  l0_rd_out,
    output rf_pkg::reg_idx_t  l0_rj_out,
    output rf_pkg::reg_idx_t  l0_rk_out,
    output rf_pkg::word_t     l0_pc_out,
    output rf_pkg::word_t     l0_pc_next_out,
    output rf_pkg::exp_t      l0_exp_out,
    output rf_pkg::word_t     l0_imm_out,
    output rf_pkg::word_t     l0_src_a,
    output rf_pkg::word_t     l0_src_b,
    output logic              l1_en_out,
    output rf_pkg::uop_t      l1_uop_out,
    output rf_pkg::reg_idx_t  l1_rd_out,
    output rf_pkg::reg_idx_t  l1_rj_out,
    output rf_pkg::reg_idx_t  l1_rk_out,
    output rf_pkg::word_t     l1_pc_out,
    output rf_pkg::word_t     l1_pc_next_out,
    output rf_pkg::exp_t      l1_exp_out,
    output rf_pkg::word_t     l1_src_a,
    output rf_pkg::word_t     l1_src_b
);
    import rf_pkg::*;

    word_t rf_0a, rf_0b, rf_1a, rf_1b;
    word_t sel_0a, sel_0b, sel_1a, sel_1b;

    regfile_2w4r u_regfile (
        .clk        (clk),
        .wr_en_0    (wr_en_0),
        .wr_en_1    (wr_en_1),
        .wr_addr_0  (wr_addr_0),
        .wr_addr_1  (wr_addr_1),
        .wr_data_0  (wr_data_0),
        .wr_data_1  (wr_data_1),
        .rd_addr_0a (l0_rj),
        .rd_addr_0b (l0_rk),
        .rd_addr_1a (l1_rj),
        .rd_addr_1b (l1_rk),
        .rd_data_0a (rf_0a),
        .rd_data_0b (rf_0b),
        .rd_data_1a (rf_1a),
        .rd_data_1b (rf_1b)
    );

    operand_select #(.sel_alu_only(1'b1)) u_sel_l0 (
        .uop   (l0_uop),
        .pc    (l0_pc),
        .imm   (l0_imm),
        .count (count),
        .rf_a  (rf_0a),
        .rf_b  (rf_0b),
        .src_a (sel_0a),
        .src_b (sel_0b)
    );

    operand_select #(.sel_alu_only(1'b0)) u_sel_l1 (
        .uop   (l1_uop),
        .pc    (l1_pc),
        .imm   (l1_imm),
        .count (count),
        .rf_a  (rf_1a),
        .rf_b  (rf_1b),
        .src_a (sel_1a),
        .src_b (sel_1b)
    );

    // en_out follows en every cycle. the payload holds while en is low.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            l0_en_out      <= 1'b0;
            l0_uop_out     <= '0;
            l0_rd_out      <= '0;
            l0_rj_out      <= '0;
            l0_rk_out      <= '0;
            l0_pc_out      <= '0;
            l0_pc_next_out <= '0;
            l0_exp_out     <= '0;
            l0_imm_out     <= '0;
            l0_src_a       <= '0;
            l0_src_b       <= '0;
        end else begin
            l0_en_out <= l0_en;
            if (l0_en) begin
                l0_uop_out     <= l0_uop;
                l0_rd_out      <= l0_rd;
                l0_rj_out      <= l0_rj;
                l0_rk_out      <= l0_rk;
                l0_pc_out      <= l0_pc;
                l0_pc_next_out <= l0_pc_next;
                l0_exp_out     <= l0_exp;
                l0_imm_out     <= l0_imm;
                l0_src_a       <= sel_0a;
                l0_src_b       <= sel_0b;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            l1_en_out      <= 1'b0;
            l1_uop_out     <= '0;
            l1_rd_out      <= '0;
            l1_rj_out      <= '0;
            l1_rk_out      <= '0;
            l1_pc_out      <= '0;
            l1_pc_next_out <= '0;
            l1_exp_out     <= '0;
            l1_src_a       <= '0;
            l1_src_b       <= '0;
        end else begin
            l1_en_out <= l1_en;
            if (l1_en) begin
                l1_uop_out     <= l1_uop;
                l1_rd_out      <= l1_rd;
                l1_rj_out      <= l1_rj;
                l1_rk_out      <= l1_rk;
                l1_pc_out      <= l1_pc;
                l1_pc_next_out <= l1_pc_next;
                l1_exp_out     <= l1_exp;
                l1_src_a       <= sel_1a;
                l1_src_b       <= sel_1b;
            end
        end
    end

endmodule

// ==== hdl/rf_subsystem_top.sv ====
`timescale 1ns/1ps

module rf_subsystem_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr_en_0,
    input  logic              wr_en_1,
    input  rf_pkg::reg_idx_t  wr_addr_0,
    input  rf_pkg::reg_idx_t  wr_addr_1,
    input  rf_pkg::word_t     wr_data_0,
    input  rf_pkg::word_t     wr_data_1,
    input  logic              l0_en,
    input  rf_pkg::uop_t      l0_uop,
    input  rf_pkg::reg_idx_t  l0_rd,
    input  rf_pkg::reg_idx_t  l0_rj,
    input  rf_pkg::reg_idx_t  l0_rk,
    input  rf_pkg::word_t     l0_pc,
    input  rf_pkg::word_t     l0_pc_next,
    input  rf_pkg::exp_t      l0_exp,
    input  rf_pkg::word_t     l0_imm,
    input  logic              l1_en,
    input  rf_pkg::uop_t      l1_uop,
    input  rf_pkg::reg_idx_t  l1_rd,
    input  rf_pkg::reg_idx_t  l1_rj,
    input  rf_pkg::reg_idx_t  l1_rk,
    input  rf_pkg::word_t     l1_pc,
    input  rf_pkg::word_t     l1_pc_next,
    input  rf_pkg::exp_t      l1_exp,
    input  rf_pkg::word_t     l1_imm,
    output logic              l0_en_out,
    output rf_pkg::uop_t      l0_uop_out,
    output rf_pkg::reg_idx_t  l0_rd_out,
    output rf_pkg::reg_idx_t  l0_rj_out,
    output rf_pkg::reg_idx_t  l0_rk_out,
    output rf_pkg::word_t     l0_pc_out,
    output rf_pkg::word_t     l0_pc_next_out,
    output rf_pkg::exp_t      l0_exp_out,
    output rf_pkg::word_t     l0_imm_out,
    output rf_pkg::word_t     l0_src_a,
    output rf_pkg::word_t     l0_src_b,
    output logic              l1_en_out,
    output rf_pkg::uop_t      l1_uop_out,
    output rf_pkg::reg_idx_t  l1_rd_out,
    output rf_pkg::reg_idx_t  l1_rj_out,
    output rf_pkg::reg_idx_t  l1_rk_out,
    output rf_pkg::word_t     l1_pc_out,
    output rf_pkg::word_t     l1_pc_next_out,
    output rf_pkg::exp_t      l1_exp_out,
    output rf_pkg::word_t     l1_src_a,
    output rf_pkg::word_t     l1_src_b
);
    import rf_pkg::*;

    cnt_t count;

    stable_counter u_counter (
        .clk    (clk),
        .arst_n (arst_n),
        .count  (count)
    );

    // every stage port has a top-level port or wire of the same name.
    rf_read_stage u_stage (.*);

endmodule

// ==== testbench/rf_stage_props.sv ====
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_stage_props (
    input logic              clk,
    input logic              arst_n,
    input logic              l0_en,
    input logic              l1_en,
    input logic              l0_en_out,
    input logic              l1_en_out,
    input rf_pkg::reg_idx_t  l0_rj,
    input rf_pkg::reg_idx_t  l1_rj,
    input rf_pkg::uop_t      l0_uop,
    input rf_pkg::uop_t      l1_uop,
    input rf_pkg::word_t     l0_src_a,
    input rf_pkg::word_t     l1_src_a
);
    import rf_pkg::*;

    logic l0_rf_a;
    logic l1_rf_a;

    // lane 0 reads rj from the array for every non-ALU op.
    assign l0_rf_a = (l0_uop[`UOP_TYPE] != `ITYPE_IDX_ALU) || (l0_uop[`UOP_SRC1] == `CTRL_SRC1_RF);
    assign l1_rf_a = (l1_uop[`UOP_SRC1] == `CTRL_SRC1_RF);

    a_reset_en: assert property (@(posedge clk) !arst_n |-> !l0_en_out && !l1_en_out)
        else $error("en_out high while in reset");

    a_l0_en: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> l0_en_out == $past(l0_en))
        else $error("lane 0 en_out does not follow en");

    a_l1_en: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> l1_en_out == $past(l1_en))
        else $error("lane 1 en_out does not follow en");

    a_l0_r0: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) && $past(l0_en) && $past(l0_rj) == 5'd0 && $past(l0_rf_a)
        |-> l0_src_a == 32'd0)
        else $error("lane 0 read of r0 is not zero");

    a_l1_r0: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) && $past(l1_en) && $past(l1_rj) == 5'd0 && $past(l1_rf_a)
        |-> l1_src_a == 32'd0)
        else $error("lane 1 read of r0 is not zero");

endmodule

bind rf_read_stage rf_stage_props u_props (.*);

// ==== testbench/rf_stage_tb.sv ====
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_stage_tb;
    import rf_pkg::*;

    typedef struct {
        int       test;
        logic     we0, we1;
        reg_idx_t wa0, wa1;
        word_t    wd0, wd1;
        logic     en[2];
        uop_t     uop[2];
        reg_idx_t rd[2], rj[2], rk[2];
        word_t    pc[2], imm[2], exp_a[2], exp_b[2];
        exp_t     ex[2];
        int       cnt_b[2];
    } row_t;

    logic clk, arst_n, wr_en_0, wr_en_1, l0_en, l1_en, l0_en_out, l1_en_out;
    reg_idx_t wr_addr_0, wr_addr_1, l0_rd, l0_rj, l0_rk, l1_rd, l1_rj, l1_rk;
    reg_idx_t l0_rd_out, l0_rj_out, l0_rk_out, l1_rd_out, l1_rj_out, l1_rk_out;
    word_t wr_data_0, wr_data_1, l0_pc, l0_pc_next, l0_imm, l1_pc, l1_pc_next, l1_imm;
    word_t l0_pc_out, l0_pc_next_out, l0_imm_out, l0_src_a, l0_src_b;
    word_t l1_pc_out, l1_pc_next_out, l1_src_a, l1_src_b;
    uop_t l0_uop, l1_uop, l0_uop_out, l1_uop_out;
    exp_t l0_exp, l1_exp, l0_exp_out, l1_exp_out;

    row_t   rows[$];
    row_t   cur;
    word_t  model[32];
    word_t  lfsr;
    word_t  held_a[2], held_b[2];
    int     last[2];
    int     errors, test_err;
    cnt_t   edges;
    string  names[6] = '{"", "reset and fill", "forwarding", "operand sources",
                         "lane asymmetry", "enable and hold"};

    rf_subsystem_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(40 * 500);
        $display("simulation did not finish in time");
        $display("Errors found");
        $finish;
    end

    // Galois LFSR, one step per bit taken.
    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic uop_t make_uop(logic [3:0] t, src1_sel_t s1, src2_sel_t s2);
        uop_t u;
        u = '0;
        u[`UOP_TYPE] = t;
        u[`UOP_SRC1] = s1;
        u[`UOP_SRC2] = s2;
        return u;
    endfunction

    task automatic note_error(string what, string got, string exp);
        $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got, exp);
        errors++;
        test_err++;
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) note_error(what, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_idx(string what, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) note_error(what, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_uop(string what, uop_t got, uop_t exp);
        if (got !== exp) note_error(what, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_exp(string what, exp_t got, exp_t exp);
        if (got !== exp) note_error(what, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_en(string what, logic got, logic exp);
        if (got !== exp) note_error(what, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic start_row(int test);
        cur.test = test;
        cur.we0 = 1'b0;
        cur.we1 = 1'b0;
        cur.wa0 = '0;
        cur.wa1 = '0;
        cur.wd0 = '0;
        cur.wd1 = '0;
        for (int l = 0; l < 2; l++) begin
            cur.en[l] = 1'b0;
            cur.uop[l] = '0;
            cur.rd[l] = '0;
            cur.rj[l] = '0;
            cur.rk[l] = '0;
            cur.pc[l] = '0;
            cur.imm[l] = '0;
            cur.ex[l] = '0;
            cur.exp_a[l] = '0;
            cur.exp_b[l] = '0;
            cur.cnt_b[l] = 0;
        end
    endtask

    task automatic set_write(int port, int addr);
        word_t d;
        d = rand_bits(32);
        if (port == 0) begin
            cur.we0 = 1'b1;
            cur.wa0 = reg_idx_t'(addr);
            cur.wd0 = d;
        end else begin
            cur.we1 = 1'b1;
            cur.wa1 = reg_idx_t'(addr);
            cur.wd1 = d;
        end
    endtask

    task automatic set_lane(int l, uop_t u, int rj, int rk);
        word_t w;
        cur.en[l] = 1'b1;
        cur.uop[l] = u;
        cur.rj[l] = reg_idx_t'(rj);
        cur.rk[l] = reg_idx_t'(rk);
        w = rand_bits(5);
        cur.rd[l] = w[4:0];
        w = rand_bits(7);
        cur.ex[l] = w[6:0];
        cur.imm[l] = rand_bits(32);
        cur.pc[l] = 32'h1c00_0000 + word_t'(rows.size() * 8 + l * 4);
    endtask

    // applies the row's writes to the model, then works out the operands.
    task automatic push_row();
        logic use_sel;
        if (cur.we0 && cur.wa0 != 5'd0) model[cur.wa0] = cur.wd0;
        if (cur.we1 && cur.wa1 != 5'd0) model[cur.wa1] = cur.wd1;
        for (int l = 0; l < 2; l++) begin
            use_sel = (l == 1) || (cur.uop[l][`UOP_TYPE] == `ITYPE_IDX_ALU);
            cur.exp_a[l] = model[cur.rj[l]];
            cur.exp_b[l] = model[cur.rk[l]];
            if (use_sel) begin
                case (cur.uop[l][`UOP_SRC1])
                    `CTRL_SRC1_PC:   cur.exp_a[l] = cur.pc[l];
                    `CTRL_SRC1_ZERO, `CTRL_SRC1_CNTID: cur.exp_a[l] = '0;
                    default: ;
                endcase
                case (cur.uop[l][`UOP_SRC2])
                    `CTRL_SRC2_IMM:  cur.exp_b[l] = cur.imm[l];
                    `CTRL_SRC2_CNTL: cur.cnt_b[l] = 1;
                    `CTRL_SRC2_CNTH: cur.cnt_b[l] = 2;
                    default: ;
                endcase
            end
        end
        rows.push_back(cur);
    endtask

    task automatic drive_row(row_t r);
        wr_en_0 <= r.we0;
        wr_en_1 <= r.we1;
        wr_addr_0 <= r.wa0;
        wr_addr_1 <= r.wa1;
        wr_data_0 <= r.wd0;
        wr_data_1 <= r.wd1;
        l0_en <= r.en[0];
        l0_uop <= r.uop[0];
        l0_rd <= r.rd[0];
        l0_rj <= r.rj[0];
        l0_rk <= r.rk[0];
        l0_pc <= r.pc[0];
        l0_pc_next <= r.pc[0] + 32'd4;
        l0_exp <= r.ex[0];
        l0_imm <= r.imm[0];
        l1_en <= r.en[1];
        l1_uop <= r.uop[1];
        l1_rd <= r.rd[1];
        l1_rj <= r.rj[1];
        l1_rk <= r.rk[1];
        l1_pc <= r.pc[1];
        l1_pc_next <= r.pc[1] + 32'd4;
        l1_exp <= r.ex[1];
        l1_imm <= r.imm[1];
    endtask

    task automatic build_table();
        uop_t alu_rf;
        alu_rf = make_uop(`ITYPE_IDX_ALU, `CTRL_SRC1_RF, `CTRL_SRC2_RF);
        for (int r = 1; r <= 31; r += 2) begin
            start_row(1);
            set_write(0, r);
            if (r < 31) set_write(1, r + 1);
            push_row();
        end
        for (int r = 0; r < 32; r += 2) begin
            start_row(1);
            set_lane(0, alu_rf, r, 31 - r);
            set_lane(1, alu_rf, r + 1, (r + 7) % 32);
            push_row();
        end
        start_row(2);
        set_write(0, 3);
        set_lane(0, alu_rf, 3, 4);
        set_lane(1, alu_rf, 4, 3);
        push_row();
        start_row(2);
        set_write(0, 7);
        set_write(1, 7);
        set_lane(0, alu_rf, 7, 3);
        set_lane(1, alu_rf, 7, 7);
        push_row();
        start_row(2);
        set_write(0, 0);
        set_write(1, 0);
        set_lane(0, alu_rf, 7, 0);
        set_lane(1, alu_rf, 0, 7);
        push_row();
        start_row(3);
        set_lane(0, make_uop(`ITYPE_IDX_ALU, `CTRL_SRC1_PC, `CTRL_SRC2_IMM), 9, 10);
        set_lane(1, make_uop(`ITYPE_IDX_ALU, `CTRL_SRC1_ZERO, `CTRL_SRC2_CNTL), 11, 12);
        push_row();
        start_row(3);
        set_lane(0, make_uop(`ITYPE_IDX_ALU, `CTRL_SRC1_CNTID, `CTRL_SRC2_CNTH), 13, 14);
        set_lane(1, make_uop(`ITYPE_IDX_ALU, `CTRL_SRC1_PC, `CTRL_SRC2_CNTH), 15, 16);
        push_row();
        start_row(3);
        set_lane(0, make_uop(`ITYPE_IDX_ALU, `CTRL_SRC1_ZERO, `CTRL_SRC2_CNTL), 17, 18);
        set_lane(1, make_uop(`ITYPE_IDX_ALU, `CTRL_SRC1_CNTID, `CTRL_SRC2_IMM), 19, 20);
        push_row();
        start_row(4);
        set_lane(0, make_uop(4'd2, `CTRL_SRC1_PC, `CTRL_SRC2_IMM), 5, 6);
        set_lane(1, make_uop(4'd2, `CTRL_SRC1_PC, `CTRL_SRC2_IMM), 5, 6);
        push_row();
        start_row(4);
        set_lane(0, make_uop(4'd3, `CTRL_SRC1_ZERO, `CTRL_SRC2_CNTL), 21, 22);
        set_lane(1, make_uop(4'd3, `CTRL_SRC1_ZERO, `CTRL_SRC2_CNTL), 21, 22);
        push_row();
        start_row(5);
        set_lane(0, alu_rf, 23, 24);
        set_lane(1, make_uop(4'd5, `CTRL_SRC1_PC, `CTRL_SRC2_IMM), 25, 26);
        push_row();
        // the lane inputs change while en is low and must be ignored.
        for (int n = 0; n < 2; n++) begin
            start_row(5);
            set_write(0, 23);
            set_lane(0, alu_rf, 23, 1);
            set_lane(1, alu_rf, 2, 3);
            cur.en[0] = 1'b0;
            cur.en[1] = 1'b0;
            push_row();
        end
    endtask

    task automatic wait_en_out(row_t r);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((l0_en_out !== r.en[0] || l1_en_out !== r.en[1]) && n < 4);
        if (l0_en_out !== r.en[0] || l1_en_out !== r.en[1]) begin
            $display("en_out did not follow en within 4 cycles");
            errors++;
            test_err++;
        end
    endtask

    task automatic check_lane(int l, int i, uop_t u, reg_idx_t rd, reg_idx_t rj,
                              reg_idx_t rk, word_t pc, word_t pcn, exp_t ex,
                              word_t a, word_t b);
        row_t r;
        cnt_t cnt;
        // the counter captured at the sampling edge lags the edge count by one.
        cnt = edges - 64'd1;
        if (rows[i].en[l]) begin
            last[l] = i;
            held_a[l] = rows[i].exp_a[l];
            held_b[l] = rows[i].cnt_b[l] == 1 ? cnt[31:0] :
                        rows[i].cnt_b[l] == 2 ? cnt[63:32] : rows[i].exp_b[l];
        end
        check_word($sformatf("row %0d lane %0d src_a", i, l), a, held_a[l]);
        check_word($sformatf("row %0d lane %0d src_b", i, l), b, held_b[l]);
        if (last[l] >= 0) begin
            r = rows[last[l]];
            check_uop($sformatf("row %0d lane %0d uop", i, l), u, r.uop[l]);
            check_idx($sformatf("row %0d lane %0d rd", i, l), rd, r.rd[l]);
            check_idx($sformatf("row %0d lane %0d rj", i, l), rj, r.rj[l]);
            check_idx($sformatf("row %0d lane %0d rk", i, l), rk, r.rk[l]);
            check_word($sformatf("row %0d lane %0d pc", i, l), pc, r.pc[l]);
            check_word($sformatf("row %0d lane %0d pc_next", i, l), pcn, r.pc[l] + 32'd4);
            check_exp($sformatf("row %0d lane %0d exp", i, l), ex, r.ex[l]);
            if (l == 0) check_word($sformatf("row %0d imm", i), l0_imm_out, r.imm[0]);
        end
    endtask

    initial begin
        int n;
        arst_n = 1'b0;
        lfsr = 32'h9aaa;
        errors = 0;
        test_err = 0;
        edges = '0;
        for (int k = 0; k < 32; k++) model[k] = '0;
        for (int l = 0; l < 2; l++) begin
            last[l] = -1;
            held_a[l] = '0;
            held_b[l] = '0;
        end
        start_row(0);
        drive_row(cur);
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_en("en_out 0 in reset", l0_en_out, 1'b0);
        check_en("en_out 1 in reset", l1_en_out, 1'b0);
        check_word("lane 0 src_a in reset", l0_src_a, '0);
        check_word("lane 0 src_b in reset", l0_src_b, '0);
        check_word("lane 1 src_a in reset", l1_src_a, '0);
        check_word("lane 1 src_b in reset", l1_src_b, '0);
        @(posedge clk);
        arst_n <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (arst_n !== 1'b1 && n < 4);
        if (arst_n !== 1'b1) begin
            $display("reset was not released");
            errors++;
        end
        // one row enters per cycle and is checked after the edge that samples it.
        @(posedge clk);
        edges = edges + 64'd1;
        drive_row(rows[0]);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            edges = edges + 64'd1;
            if (i + 1 < rows.size()) begin
                drive_row(rows[i + 1]);
            end
            wait_en_out(rows[i]);
            check_en($sformatf("row %0d l0_en_out", i), l0_en_out, rows[i].en[0]);
            check_en($sformatf("row %0d l1_en_out", i), l1_en_out, rows[i].en[1]);
            check_lane(0, i, l0_uop_out, l0_rd_out, l0_rj_out, l0_rk_out, l0_pc_out,
                       l0_pc_next_out, l0_exp_out, l0_src_a, l0_src_b);
            check_lane(1, i, l1_uop_out, l1_rd_out, l1_rj_out, l1_rk_out, l1_pc_out,
                       l1_pc_next_out, l1_exp_out, l1_src_a, l1_src_b);
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                $display("test %0d, %s: %s", rows[i].test, names[rows[i].test],
                         test_err == 0 ? "passed" : "failed");
                test_err = 0;
            end
        end
        $display("%0d rows checked, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== rf_stage.f ====
+incdir+hdl
hdl/rf_pkg.sv
hdl/stable_counter.sv
hdl/regfile_2w4r.sv
hdl/operand_select.sv
hdl/rf_read_stage.sv
hdl/rf_subsystem_top.sv
testbench/rf_stage_props.sv
testbench/rf_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the register-read stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rf_stage.f \
    --top-module rf_stage_tb -o rf_stage_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/rf_stage_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "No errors" <<< "$sim_out"; then
    exit 0
fi
exit 1
